//--- src/riscv_pkg.sv
package riscv_pkg;

  // major opcodes kept by this core
  typedef enum logic [6:0] {
    OPC_OTHER  = 7'b0000000,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'b000,
    F3_SLL     = 3'b001,
    F3_SLT     = 3'b010,
    F3_SLTU    = 3'b011,
    F3_XOR     = 3'b100,
    F3_SRL_SRA = 3'b101,
    F3_OR      = 3'b110,
    F3_AND     = 3'b111
  } funct3_e;

  // encoding seen by the ALU station
  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_AND  = 5'd2,
    ALU_OR   = 5'd3,
    ALU_XOR  = 5'd4,
    ALU_SLL  = 5'd5,
    ALU_SRL  = 5'd6,
    ALU_SRA  = 5'd7,
    ALU_SLT  = 5'd8,
    ALU_SLTU = 5'd9
  } alu_op_e;

  function automatic opcode_e opcode_of(input logic [31:0] instr);
    return opcode_e'(instr[6:0]);
  endfunction

  function automatic funct3_e funct3_of(input logic [31:0] instr);
    return funct3_e'(instr[14:12]);
  endfunction

  function automatic logic [6:0] funct7_of(input logic [31:0] instr);
    return instr[31:25];
  endfunction

  function automatic logic [31:0] imm_i(input logic [31:0] instr);
    return {{20{instr[31]}}, instr[31:20]};
  endfunction

  function automatic logic [31:0] imm_u(input logic [31:0] instr);
    return {instr[31:12], 12'b0};
  endfunction

endpackage

//--- src/rob_pkg.sv
package rob_pkg;

  import riscv_pkg::*;

  // tag width bounds the queue depth to 2**TAG_W
  localparam int TAG_W = 4;

  typedef logic [TAG_W-1:0] rob_tag_t;

  // how an entry gets its value
  typedef enum logic [1:0] {
    CLS_ALU       = 2'd0,
    CLS_RESOLVED  = 2'd1,
    CLS_NOP_WRITE = 2'd2
  } inst_class_e;

  typedef enum logic [1:0] {
    ST_WAITING = 2'd0,
    ST_ISSUED  = 2'd1,
    ST_DONE    = 2'd2
  } entry_state_e;

  typedef struct packed {
    inst_class_e  cls;
    entry_state_e state;
    logic [31:0]  instr;
    logic [4:0]   rd;
    logic [31:0]  value;
    logic [31:0]  pc;
    // compressed-size instruction
    logic         half;
  } rob_entry_t;

  typedef struct packed {
    logic        valid;
    rob_tag_t    tag;
    logic [31:0] value;
  } cdb_t;

  // vj/vk only meaningful when the matching pending bit is low
  typedef struct packed {
    alu_op_e     op;
    logic [31:0] vj;
    logic [31:0] vk;
    logic        qj_pending;
    rob_tag_t    qj;
    logic        qk_pending;
    rob_tag_t    qk;
    rob_tag_t    dest;
  } rs_packet_t;

  typedef struct packed {
    logic        pending;
    rob_tag_t    tag;
    logic [31:0] value;
  } reg_status_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] value;
    rob_tag_t    tag;
  } commit_t;

endpackage

//--- src/rob_ingress.sv
`timescale 1ns/1ps

module rob_ingress
  import riscv_pkg::*;
  import rob_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid,
  output logic        in_ready,
  input  logic [31:0] in_instr,
  input  logic [31:0] in_pc,
  input  logic        in_half,
  output logic        alloc_valid,
  input  logic        alloc_ready,
  output rob_entry_t  alloc_entry
);

  rob_entry_t next_entry;

  // the stage drains whenever alloc_ready is high, so it can refill on the same edge
  assign in_ready = alloc_ready;

  always_comb begin
    next_entry       = '0;
    next_entry.state = ST_WAITING;
    next_entry.instr = in_instr;
    next_entry.pc    = in_pc;
    next_entry.half  = in_half;
    next_entry.rd    = in_instr[11:7];
    case (opcode_of(in_instr))
      OPC_OP_IMM, OPC_OP: begin
        next_entry.cls = CLS_ALU;
      end
      OPC_LUI: begin
        next_entry.cls   = CLS_RESOLVED;
        next_entry.value = imm_u(in_instr);
      end
      OPC_AUIPC: begin
        next_entry.cls   = CLS_RESOLVED;
        next_entry.value = in_pc + imm_u(in_instr);
      end
      OPC_JAL: begin
        // link address, short step for a half-size jal
        next_entry.cls   = CLS_RESOLVED;
        next_entry.value = in_pc + (in_half ? 32'd2 : 32'd4);
      end
      default: begin
        next_entry.cls = CLS_NOP_WRITE;
        next_entry.rd  = 5'd0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      alloc_valid <= 1'b0;
    end else if (in_ready) begin
      alloc_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      alloc_entry <= next_entry;
    end
  end

endmodule

//--- src/rob_queue.sv
`timescale 1ns/1ps

module rob_queue
  import rob_pkg::*;
#(
  parameter int ROB_DEPTH = 16
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 alloc_valid,
  output logic                 alloc_ready,
  input  rob_entry_t           alloc_entry,
  output rob_entry_t           disp_entry,
  output rob_tag_t             disp_tag,
  output logic                 disp_valid,
  input  logic                 dispatch_done,
  input  logic                 issue_mark,
  input  rob_tag_t [1:0]       lookup_tag,
  output rob_entry_t [1:0]     lookup_entry,
  input  cdb_t                 cdb,
  output rob_entry_t           head_entry,
  output rob_tag_t             head_tag,
  output logic                 head_valid,
  input  logic                 pop
);

  localparam int PTR_W = $clog2(ROB_DEPTH);

  rob_entry_t entries [ROB_DEPTH];

  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [PTR_W-1:0] disp_ptr;
  logic [PTR_W:0]   count;
  logic [PTR_W:0]   disp_count;
  logic [PTR_W:0]   count_next;
  logic             alloc_fire;

  assign alloc_fire = alloc_valid && alloc_ready;
  assign count_next = count + (PTR_W+1)'(alloc_fire) - (PTR_W+1)'(pop);

  assign disp_entry = entries[disp_ptr];
  assign disp_tag   = rob_tag_t'(disp_ptr);
  assign disp_valid = disp_count != '0;
  assign head_entry = entries[head];
  assign head_tag   = rob_tag_t'(head);
  assign head_valid = count != '0;

  // bypass lookup, a result on the bus this cycle counts as done
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      lookup_entry[k] = entries[lookup_tag[k][PTR_W-1:0]];
      if (cdb.valid && cdb.tag == lookup_tag[k]) begin
        lookup_entry[k].state = ST_DONE;
        lookup_entry[k].value = cdb.value;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head        <= '0;
      tail        <= '0;
      disp_ptr    <= '0;
      count       <= '0;
      disp_count  <= '0;
      alloc_ready <= 1'b0;
    end else begin
      if (alloc_fire) tail <= tail + 1'b1;
      if (pop) head <= head + 1'b1;
      if (dispatch_done) disp_ptr <= disp_ptr + 1'b1;
      count       <= count_next;
      disp_count  <= disp_count + (PTR_W+1)'(alloc_fire) - (PTR_W+1)'(dispatch_done);
      // keep one spare slot so a just-retired entry stays readable for a cycle
      alloc_ready <= count_next <= (PTR_W+1)'(ROB_DEPTH - 2);
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_fire) begin
      entries[tail] <= alloc_entry;
    end
    if (dispatch_done) begin
      entries[disp_ptr].state <= issue_mark ? ST_ISSUED : ST_DONE;
    end
    if (cdb.valid) begin
      entries[cdb.tag[PTR_W-1:0]].value <= cdb.value;
      entries[cdb.tag[PTR_W-1:0]].state <= ST_DONE;
    end
  end

endmodule

//--- src/rob_dispatch.sv
`timescale 1ns/1ps

module rob_dispatch
  import riscv_pkg::*;
  import rob_pkg::*;
#(
  parameter int ROB_DEPTH = 16
) (
  input  logic             clk,
  input  logic             rst,
  input  rob_entry_t       disp_entry,
  input  rob_tag_t         disp_tag,
  input  logic             disp_valid,
  output logic             dispatch_done,
  output logic             issue_mark,
  output rob_tag_t [1:0]   lookup_tag,
  input  rob_entry_t [1:0] lookup_entry,
  output logic [4:0]       rs1_addr,
  output logic [4:0]       rs2_addr,
  input  reg_status_t      rs1_status,
  input  reg_status_t      rs2_status,
  output logic             rename_valid,
  output logic [4:0]       rename_rd,
  output rob_tag_t         rename_tag,
  output logic             rs_valid,
  input  logic             rs_ready,
  output rs_packet_t       rs_packet
);

  localparam int PTR_W = $clog2(ROB_DEPTH);

  logic [31:0] instr;
  funct3_e     f3;
  logic        is_reg_op;
  logic        is_alu;
  logic        waiting;
  logic        stage_free;
  alu_op_e     alu_op;
  logic        src1_pending;
  logic        src2_pending;
  logic [31:0] src1_value;
  logic [31:0] src2_value;
  rs_packet_t  pkt;

  // register value, else producer value if done, else wait on the tag
  function automatic void resolve_src(
    input  reg_status_t st,
    input  rob_entry_t  producer,
    output logic        pending,
    output logic [31:0] value
  );
    pending = 1'b0;
    value   = st.value;
    if (st.pending) begin
      if (producer.state == ST_DONE) begin
        value = producer.value;
      end else begin
        pending = 1'b1;
        value   = '0;
      end
    end
  endfunction

  assign instr      = disp_entry.instr;
  assign f3         = funct3_of(instr);
  assign is_reg_op  = opcode_of(instr) == OPC_OP;
  assign rs1_addr   = instr[19:15];
  assign rs2_addr   = instr[24:20];
  assign lookup_tag = {rs2_status.tag, rs1_status.tag};

  always_comb begin
    resolve_src(rs1_status, lookup_entry[0], src1_pending, src1_value);
    resolve_src(rs2_status, lookup_entry[1], src2_pending, src2_value);
  end

  // reference op mapping, nonzero funct7 selects sub and sra
  always_comb begin
    case (f3)
      F3_ADD_SUB: alu_op = (is_reg_op && funct7_of(instr) != 7'd0) ? ALU_SUB : ALU_ADD;
      F3_SLL:     alu_op = ALU_SLL;
      F3_SLT:     alu_op = ALU_SLT;
      F3_SLTU:    alu_op = ALU_SLTU;
      F3_XOR:     alu_op = ALU_XOR;
      F3_SRL_SRA: alu_op = (funct7_of(instr) != 7'd0) ? ALU_SRA : ALU_SRL;
      F3_OR:      alu_op = ALU_OR;
      default:    alu_op = ALU_AND;
    endcase
  end

  always_comb begin
    pkt            = '0;
    pkt.op         = alu_op;
    pkt.vj         = src1_value;
    pkt.qj_pending = src1_pending;
    pkt.qj         = src1_pending ? rs1_status.tag : '0;
    pkt.dest       = rob_tag_t'(disp_tag[PTR_W-1:0]);
    if (is_reg_op) begin
      pkt.vk         = src2_value;
      pkt.qk_pending = src2_pending;
      pkt.qk         = src2_pending ? rs2_status.tag : '0;
    end else if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
      pkt.vk = {27'd0, instr[24:20]};
    end else begin
      pkt.vk = imm_i(instr);
    end
  end

  assign waiting    = disp_valid && disp_entry.state == ST_WAITING;
  assign is_alu     = disp_entry.cls == CLS_ALU;
  assign stage_free = !rs_valid || rs_ready;

  // resolved entries pass even while the station output is held
  assign dispatch_done = waiting && (!is_alu || stage_free);
  assign issue_mark    = is_alu;
  assign rename_valid  = dispatch_done && disp_entry.cls != CLS_NOP_WRITE &&
                         disp_entry.rd != 5'd0;
  assign rename_rd     = disp_entry.rd;
  assign rename_tag    = disp_tag;

  always_ff @(posedge clk) begin
    if (rst) begin
      rs_valid <= 1'b0;
    end else if (dispatch_done && is_alu) begin
      rs_valid <= 1'b1;
    end else if (rs_ready) begin
      rs_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (dispatch_done && is_alu) begin
      rs_packet <= pkt;
    end
  end

endmodule

//--- src/reg_status_file.sv
`timescale 1ns/1ps

module reg_status_file
  import rob_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  output reg_status_t rs1_status,
  output reg_status_t rs2_status,
  input  logic        rename_valid,
  input  logic [4:0]  rename_rd,
  input  rob_tag_t    rename_tag,
  input  logic        commit_valid,
  input  logic [4:0]  commit_rd,
  input  rob_tag_t    commit_tag,
  input  logic [31:0] commit_value
);

  reg_status_t regs [32];

  // x0 reads as zero, never pending
  assign rs1_status = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_status = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (commit_valid && commit_rd != 5'd0) begin
        regs[commit_rd].value <= commit_value;
        // a younger producer keeps its claim
        if (regs[commit_rd].pending && regs[commit_rd].tag == commit_tag) begin
          regs[commit_rd].pending <= 1'b0;
        end
      end
      // later assignment, so a same-cycle rename wins
      if (rename_valid && rename_rd != 5'd0) begin
        regs[rename_rd].pending <= 1'b1;
        regs[rename_rd].tag     <= rename_tag;
      end
    end
  end

endmodule

//--- src/rob_commit.sv
`timescale 1ns/1ps

module rob_commit
  import rob_pkg::*;
#(
  parameter int ROB_DEPTH = 16
) (
  input  logic        clk,
  input  logic        rst,
  input  rob_entry_t  head_entry,
  input  rob_tag_t    head_tag,
  input  logic        head_valid,
  output logic        pop,
  output logic        commit_valid,
  output commit_t     commit,
  output logic        reg_commit_valid,
  output logic [4:0]  commit_rd,
  output rob_tag_t    commit_tag,
  output logic [31:0] commit_value
);

  localparam int PTR_W = $clog2(ROB_DEPTH);

  rob_tag_t ret_tag;
  logic     writes_reg;

  assign ret_tag    = rob_tag_t'(head_tag[PTR_W-1:0]);
  assign pop        = head_valid && head_entry.state == ST_DONE;
  // nop-class and x0 results still retire but leave the registers alone
  assign writes_reg = head_entry.cls != CLS_NOP_WRITE && head_entry.rd != 5'd0;

  always_ff @(posedge clk) begin
    if (rst) begin
      commit_valid     <= 1'b0;
      reg_commit_valid <= 1'b0;
    end else begin
      commit_valid     <= pop;
      reg_commit_valid <= pop && writes_reg;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      commit.pc    <= head_entry.pc;
      commit.rd    <= head_entry.rd;
      commit.value <= head_entry.value;
      commit.tag   <= ret_tag;
      commit_rd    <= head_entry.rd;
      commit_tag   <= ret_tag;
      commit_value <= head_entry.value;
    end
  end

endmodule

//--- src/rob_top.sv
`timescale 1ns/1ps

module rob_top
  import rob_pkg::*;
#(
  parameter int ROB_DEPTH = 16
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid,
  output logic        in_ready,
  input  logic [31:0] in_instr,
  input  logic [31:0] in_pc,
  input  logic        in_half,
  output logic        rs_valid,
  input  logic        rs_ready,
  output rs_packet_t  rs_packet,
  input  cdb_t        cdb,
  output logic        commit_valid,
  output commit_t     commit
);

  logic             alloc_valid;
  logic             alloc_ready;
  rob_entry_t       alloc_entry;
  rob_entry_t       disp_entry;
  rob_tag_t         disp_tag;
  logic             disp_valid;
  logic             dispatch_done;
  logic             issue_mark;
  rob_tag_t [1:0]   lookup_tag;
  rob_entry_t [1:0] lookup_entry;
  logic [4:0]       rs1_addr;
  logic [4:0]       rs2_addr;
  reg_status_t      rs1_status;
  reg_status_t      rs2_status;
  logic             rename_valid;
  logic [4:0]       rename_rd;
  rob_tag_t         rename_tag;
  rob_entry_t       head_entry;
  rob_tag_t         head_tag;
  logic             head_valid;
  logic             pop;
  logic             reg_commit_valid;
  logic [4:0]       commit_rd;
  rob_tag_t         commit_tag;
  logic [31:0]      commit_value;

  rob_ingress ingress_inst (
    .clk, .rst, .in_valid, .in_ready, .in_instr, .in_pc, .in_half,
    .alloc_valid, .alloc_ready, .alloc_entry
  );

  rob_queue #(.ROB_DEPTH(ROB_DEPTH)) queue_inst (
    .clk, .rst, .alloc_valid, .alloc_ready, .alloc_entry,
    .disp_entry, .disp_tag, .disp_valid, .dispatch_done, .issue_mark,
    .lookup_tag, .lookup_entry, .cdb,
    .head_entry, .head_tag, .head_valid, .pop
  );

  rob_dispatch #(.ROB_DEPTH(ROB_DEPTH)) dispatch_inst (
    .clk, .rst, .disp_entry, .disp_tag, .disp_valid, .dispatch_done, .issue_mark,
    .lookup_tag, .lookup_entry, .rs1_addr, .rs2_addr, .rs1_status, .rs2_status,
    .rename_valid, .rename_rd, .rename_tag, .rs_valid, .rs_ready, .rs_packet
  );

  reg_status_file reg_status_inst (
    .clk, .rst, .rs1_addr, .rs2_addr, .rs1_status, .rs2_status,
    .rename_valid, .rename_rd, .rename_tag,
    .commit_valid(reg_commit_valid), .commit_rd, .commit_tag, .commit_value
  );

  rob_commit #(.ROB_DEPTH(ROB_DEPTH)) commit_inst (
    .clk, .rst, .head_entry, .head_tag, .head_valid, .pop,
    .commit_valid, .commit, .reg_commit_valid, .commit_rd, .commit_tag, .commit_value
  );

endmodule

//--- sim/rob_ref_model.sv
package rob_ref_model;

  // architectural registers of the in-order model
  logic [31:0] arch [32];

  function automatic void clear_state();
    for (int i = 0; i < 32; i++) begin
      arch[i] = '0;
    end
  endfunction

  // numeric codes follow the station encoding, ADD 0 up to SLTU 9
  function automatic logic [31:0] alu_calc(input logic [4:0] op, input logic [31:0] a,
                                           input logic [31:0] b);
    case (op)
      5'd0:    return a + b;
      5'd1:    return a - b;
      5'd2:    return a & b;
      5'd3:    return a | b;
      5'd4:    return a ^ b;
      5'd5:    return a << b[4:0];
      5'd6:    return a >> b[4:0];
      5'd7:    return 32'($signed(a) >>> b[4:0]);
      5'd8:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      5'd9:    return (a < b) ? 32'd1 : 32'd0;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  function automatic logic [4:0] op_code(input logic [31:0] instr);
    logic reg_form;
    logic alt;
    // bit 5 separates the register form from the immediate form
    reg_form = instr[5];
    alt      = instr[30];
    case (instr[14:12])
      3'd0:    return (reg_form && alt) ? 5'd1 : 5'd0;
      3'd1:    return 5'd5;
      3'd2:    return 5'd8;
      3'd3:    return 5'd9;
      3'd4:    return 5'd4;
      3'd5:    return alt ? 5'd7 : 5'd6;
      3'd6:    return 5'd3;
      default: return 5'd2;
    endcase
  endfunction

  // executes one instruction, gives the commit fields and the ALU operands
  function automatic void step(input logic [31:0] instr, input logic [31:0] pc,
                               input logic half, output logic [4:0] rd,
                               output logic [31:0] value, output logic [31:0] a,
                               output logic [31:0] b);
    logic [31:0] upper;
    upper = {instr[31:12], 12'h000};
    rd    = instr[11:7];
    a     = arch[instr[19:15]];
    b     = '0;
    value = '0;
    case (instr[6:0])
      7'h33: begin
        b     = arch[instr[24:20]];
        value = alu_calc(op_code(instr), a, b);
      end
      7'h13: begin
        if (instr[14:12] == 3'd1 || instr[14:12] == 3'd5) begin
          b = {27'd0, instr[24:20]};
        end else begin
          b = {{20{instr[31]}}, instr[31:20]};
        end
        value = alu_calc(op_code(instr), a, b);
      end
      7'h37: value = upper;
      7'h17: value = pc + upper;
      7'h6f: value = pc + (half ? 32'd2 : 32'd4);
      default: rd = 5'd0;
    endcase
    if (rd != 5'd0) begin
      arch[rd] = value;
    end
  endfunction

endpackage

//--- sim/tb_rob_top.sv
`timescale 1ns/1ps

module tb_rob_top
  import rob_pkg::*;
  import rob_ref_model::*;
();

  localparam int DEPTH    = 8;
  localparam int PROG_LEN = 120;
  localparam int SPLIT    = 60;

  logic        clk;
  logic        rst;
  logic        in_valid;
  logic        in_ready;
  logic [31:0] in_instr;
  logic [31:0] in_pc;
  logic        in_half;
  logic        rs_valid;
  logic        rs_ready;
  rs_packet_t  rs_packet;
  cdb_t        cdb;
  logic        commit_valid;
  commit_t     commit;

  // program and its expected results
  logic [31:0] prog_instr [PROG_LEN];
  logic [31:0] prog_pc [PROG_LEN];
  logic        prog_half [PROG_LEN];
  logic        prog_alu [PROG_LEN];
  logic        prog_reg_form [PROG_LEN];
  logic [4:0]  exp_rd [PROG_LEN];
  logic [31:0] exp_value [PROG_LEN];
  logic [31:0] exp_a [PROG_LEN];
  logic [31:0] exp_b [PROG_LEN];
  // index of the older instruction writing each source, -1 if none
  int          src1_writer [PROG_LEN];
  int          src2_writer [PROG_LEN];

  // station slots
  rs_packet_t  st_pkt [16];
  logic        st_used [16];
  int          st_ready_at [16];
  rs_packet_t  held;
  logic        pkt_fresh;

  int          seed;
  int          errors;
  int          checks;
  int          accepted;
  int          committed;
  int          packets;
  int          alu_idx;
  int          alu_total;
  int          feed_limit;
  int          cycle;
  int          stall_accepted;
  logic        hold_station;
  logic        run_ok;
  string       test_name;

  rob_top #(.ROB_DEPTH(DEPTH)) rob_top_inst (
    .clk, .rst, .in_valid, .in_ready, .in_instr, .in_pc, .in_half,
    .rs_valid, .rs_ready, .rs_packet, .cdb, .commit_valid, .commit
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      errors++;
      $display("%s: %s", test_name, msg);
    end
  endtask

  task automatic build_program();
    logic [31:0] pc;
    logic [31:0] word;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    int          kind;
    int          last_writer [32];
    pc        = 32'h0000_1000;
    alu_total = 0;
    for (int r = 0; r < 32; r++) begin
      last_writer[r] = -1;
    end
    clear_state();
    for (int k = 0; k < PROG_LEN; k++) begin
      // the back-pressure part opens with an ALU op that blocks the head
      kind = (k == SPLIT) ? 4 : ($random(seed) & 15);
      rd   = 5'($random(seed) & 7);
      rs1  = 5'($random(seed) & 7);
      rs2  = 5'($random(seed) & 7);
      f3   = 3'($random(seed));
      alt  = (f3 == 3'd0 || f3 == 3'd5) ? 1'($random(seed)) : 1'b0;
      prog_half[k] = 1'b0;
      case (kind)
        0: word = {20'($random(seed)), rd, 7'h37};
        1: word = {20'($random(seed)), rd, 7'h17};
        2: begin
          word         = {20'($random(seed)), rd, 7'h6f};
          prog_half[k] = 1'($random(seed));
        end
        3: word = {25'($random(seed)), 7'h0f};
        4, 5, 6, 7, 8, 9: word = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, 7'h33};
        default: begin
          if (f3 == 3'd1 || f3 == 3'd5) begin
            word = {1'b0, alt, 5'd0, 5'($random(seed)), rs1, f3, rd, 7'h13};
          end else begin
            word = {12'($random(seed)), rs1, f3, rd, 7'h13};
          end
        end
      endcase
      prog_instr[k]    = word;
      prog_pc[k]       = pc;
      prog_alu[k]      = word[6:0] == 7'h33 || word[6:0] == 7'h13;
      prog_reg_form[k] = word[6:0] == 7'h33;
      src1_writer[k]   = last_writer[word[19:15]];
      src2_writer[k]   = last_writer[word[24:20]];
      if (prog_alu[k]) begin
        alu_total++;
      end
      step(word, pc, prog_half[k], exp_rd[k], exp_value[k], exp_a[k], exp_b[k]);
      if (exp_rd[k] != 5'd0) begin
        last_writer[exp_rd[k]] = k;
      end
      pc = pc + (prog_half[k] ? 32'd2 : 32'd4);
    end
  endtask

  // operands are either the in-order value or the tag of their producer
  task automatic check_packet(input rs_packet_t p);
    int k;
    while (alu_idx < PROG_LEN && !prog_alu[alu_idx]) begin
      alu_idx++;
    end
    if (alu_idx >= PROG_LEN) begin
      check_true(1'b0, "station packet without a matching ALU instruction");
      return;
    end
    k = alu_idx;
    alu_idx++;
    packets++;
    check_value("packet dest", k % DEPTH, p.dest);
    check_value("packet op", op_code(prog_instr[k]), p.op);
    if (p.qj_pending) begin
      check_true(src1_writer[k] >= 0 && p.qj == src1_writer[k] % DEPTH,
                 "vj waits on a tag that does not produce rs1");
    end else begin
      check_value("packet vj", exp_a[k], p.vj);
    end
    if (prog_reg_form[k] && p.qk_pending) begin
      check_true(src2_writer[k] >= 0 && p.qk == src2_writer[k] % DEPTH,
                 "vk waits on a tag that does not produce rs2");
    end else begin
      check_value("packet vk", exp_b[k], p.vk);
    end
  endtask

  function automatic rs_packet_t snoop(input rs_packet_t p, input cdb_t c);
    rs_packet_t r;
    r = p;
    if (c.valid && r.qj_pending && r.qj == c.tag) begin
      r.qj_pending = 1'b0;
      r.vj         = c.value;
    end
    if (c.valid && r.qk_pending && r.qk == c.tag) begin
      r.qk_pending = 1'b0;
      r.vk         = c.value;
    end
    return r;
  endfunction

  task automatic collect_commit();
    if (commit_valid) begin
      if (committed >= PROG_LEN) begin
        check_true(1'b0, "commit seen after the whole program retired");
      end else begin
        check_value("commit pc", prog_pc[committed], commit.pc);
        check_value("commit rd", exp_rd[committed], commit.rd);
        check_value("commit value", exp_value[committed], commit.value);
        check_value("commit tag", committed % DEPTH, commit.tag);
      end
      committed++;
    end
  endtask

  task automatic feed_input();
    if (in_valid && in_ready) begin
      accepted++;
    end
    if (!in_valid || in_ready) begin
      if (accepted < feed_limit && ($random(seed) & 3) != 0) begin
        in_valid <= 1'b1;
        in_instr <= prog_instr[accepted];
        in_pc    <= prog_pc[accepted];
        in_half  <= prog_half[accepted];
      end else begin
        in_valid <= 1'b0;
      end
    end
  endtask

  task automatic run_station();
    int   free_slot;
    int   start;
    int   idx;
    logic found;
    if (rs_valid && pkt_fresh) begin
      held = rs_packet;
      check_packet(rs_packet);
    end
    // bus value seen here was not yet visible when the held packet formed
    held = snoop(held, cdb);
    for (int i = 0; i < 16; i++) begin
      if (st_used[i]) begin
        st_pkt[i] = snoop(st_pkt[i], cdb);
      end
    end
    if (rs_valid && rs_ready) begin
      free_slot = -1;
      for (int i = 0; i < 16; i++) begin
        if (!st_used[i] && free_slot < 0) begin
          free_slot = i;
        end
      end
      if (free_slot < 0) begin
        check_true(1'b0, "station ran out of slots");
      end else begin
        st_used[free_slot]     = 1'b1;
        st_pkt[free_slot]      = held;
        st_ready_at[free_slot] = cycle + 1 + ($random(seed) & 7);
      end
    end
    pkt_fresh = !rs_valid || rs_ready;
    // random scan start gives out-of-order results
    found = 1'b0;
    start = $random(seed) & 15;
    for (int n = 0; n < 16; n++) begin
      idx = (start + n) % 16;
      if (!found && st_used[idx] && !st_pkt[idx].qj_pending && !st_pkt[idx].qk_pending &&
          cycle >= st_ready_at[idx]) begin
        found        = 1'b1;
        st_used[idx] = 1'b0;
        cdb <= {1'b1, st_pkt[idx].dest,
                alu_calc(st_pkt[idx].op, st_pkt[idx].vj, st_pkt[idx].vk)};
      end
    end
    if (!found) begin
      cdb <= '0;
    end
    rs_ready <= hold_station ? 1'b0 : (($random(seed) & 3) != 0);
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      cycle++;
      collect_commit();
      feed_input();
      run_station();
      check_true(accepted - committed <= DEPTH,
                 "more instructions outstanding than the queue can hold");
    end
  end

  task automatic check_reset_outputs();
    check_value("in_ready", 32'd0, in_ready);
    check_value("rs_valid", 32'd0, rs_valid);
    check_value("commit_valid", 32'd0, commit_valid);
  endtask

  task automatic wait_in_ready(input logic level, input int limit, output logic ok);
    int waited;
    waited = 0;
    while (in_ready !== level && waited < limit) begin
      @(posedge clk);
      waited++;
    end
    ok = in_ready === level;
    if (!ok) begin
      errors++;
      $display("%s: timeout after %0d cycles waiting for in_ready to be %0b",
               test_name, limit, level);
    end
  endtask

  task automatic wait_commits(input int target, input int limit, output logic ok);
    int waited;
    waited = 0;
    while (committed < target && waited < limit) begin
      @(posedge clk);
      waited++;
    end
    ok = committed >= target;
    if (!ok) begin
      errors++;
      $display("%s: timeout after %0d cycles waiting for %0d commits, only %0d seen",
               test_name, limit, target, committed);
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d, commits %0d, packets %0d",
             checks, errors, committed, packets);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  initial begin
    rst          = 1'b1;
    in_valid     = 1'b0;
    in_instr     = '0;
    in_pc        = '0;
    in_half      = 1'b0;
    rs_ready     = 1'b0;
    cdb          = '0;
    seed         = 32'had86_1d65;
    errors       = 0;
    checks       = 0;
    accepted     = 0;
    committed    = 0;
    packets      = 0;
    alu_idx      = 0;
    feed_limit   = 0;
    cycle        = 0;
    held         = '0;
    pkt_fresh    = 1'b1;
    hold_station = 1'b0;
    run_ok       = 1'b1;
    for (int i = 0; i < 16; i++) begin
      st_used[i] = 1'b0;
    end
    build_program();

    test_name = "reset";
    for (int c = 0; c < 8; c++) begin
      @(posedge clk);
      if (c > 0) begin
        check_reset_outputs();
      end
    end
    rst <= 1'b0;
    @(posedge clk);
    check_reset_outputs();
    wait_in_ready(1'b1, 50, run_ok);

    // mixed program with random station delays
    if (run_ok) begin
      test_name  = "random_program";
      feed_limit = SPLIT;
      wait_commits(SPLIT, 6000, run_ok);
    end

    // station stalled until the queue fills
    if (run_ok) begin
      test_name    = "back_pressure";
      hold_station = 1'b1;
      feed_limit   = PROG_LEN;
      wait_in_ready(1'b0, 2000, run_ok);
    end
    if (run_ok) begin
      stall_accepted = accepted;
      repeat (20) @(posedge clk);
      check_value("accepted while stalled", stall_accepted, accepted);
      check_value("in_ready while stalled", 32'd0, in_ready);
      hold_station = 1'b0;
      wait_commits(PROG_LEN, 8000, run_ok);
    end

    if (run_ok) begin
      test_name = "drain";
      repeat (30) @(posedge clk);
      check_value("commit count", PROG_LEN, committed);
      check_value("packet count", alu_total, packets);
      check_value("accepted count", PROG_LEN, accepted);
    end
    finish_run();
  end

endmodule

//--- rob_top.f
src/riscv_pkg.sv
src/rob_pkg.sv
src/rob_ingress.sv
src/rob_queue.sv
src/rob_dispatch.sv
src/reg_status_file.sv
src/rob_commit.sv
src/rob_top.sv
sim/rob_ref_model.sv
sim/tb_rob_top.sv
